/* Makefile */
SRCS := all.f $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: $(SRCS)
	verilator --binary --timing --Wno-fatal --top-module tb_cpu -f all.f -o Vtb_cpu

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/reg_track_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
testbench/clock_gen.sv
testbench/tb_cpu.sv

/* rtl/cpu_macros.svh */
// cpu sizes and address map
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath
`define CPU_XLEN      32
`define CPU_ADDR_W    16

// storage depths, in words
`define CPU_IM_DEPTH  64
`define CPU_DM_DEPTH  64
`define CPU_REG_COUNT 16

// stores at or above this address go out to the host
`define CPU_HOST_BASE 16'h9000

`endif

/* rtl/cpu_pkg.sv */
// cpu shared types
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h01,
        OP_SUB  = 8'h02,
        OP_AND  = 8'h03,
        OP_OR   = 8'h04,
        OP_XOR  = 8'h05,
        OP_ADDI = 8'h10,
        OP_LW   = 8'h20,
        OP_SW   = 8'h21
    } opcode_t;

    typedef enum logic {
        LOAD,
        RUN
    } fetch_state_t;

    typedef logic [3:0] reg_idx_t;

    // decode -> execute
    typedef struct packed {
        logic                 valid;
        opcode_t              op;
        reg_idx_t             rd;
        logic                 wr_en;
        logic [`CPU_XLEN-1:0] rs_val;
        logic [`CPU_XLEN-1:0] rt_val;
        logic [`CPU_XLEN-1:0] st_val;  // rd value, store data
        logic [`CPU_XLEN-1:0] imm;
    } id_ex_t;

    // execute -> memory
    typedef struct packed {
        logic                 valid;
        opcode_t              op;
        reg_idx_t             rd;
        logic                 wr_en;
        logic [`CPU_XLEN-1:0] result;
        logic [`CPU_XLEN-1:0] st_data;
    } ex_mem_t;

endpackage

/* rtl/cpu_top.sv */
// pipelined cpu core
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   prog_valid,
    output logic                   prog_ready,
    input  logic [`CPU_XLEN-1:0]   prog_data,
    input  logic                   prog_last,
    output logic                   host_wr_valid,
    input  logic                   host_wr_ready,
    output logic [`CPU_ADDR_W-1:0] host_wr_addr,
    output logic [`CPU_XLEN-1:0]   host_wr_data
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] instr;
    logic                 instr_valid;
    logic                 stall;
    logic                 freeze;  // host write back-pressure
    id_ex_t               id_ex;
    ex_mem_t              ex_mem;

    reg_track_if track ();

    fetch_stage u_fetch (
        .clk, .rst_n, .prog_valid, .prog_ready, .prog_data, .prog_last,
        .stall, .freeze, .instr, .instr_valid
    );

    decode_stage u_decode (
        .clk, .rst_n, .instr, .instr_valid, .freeze,
        .track(track.decode), .stall, .id_ex
    );

    execute_stage u_execute (
        .clk, .rst_n, .id_ex, .freeze, .track(track.execute), .ex_mem
    );

    memory_stage u_memory (
        .clk, .rst_n, .ex_mem, .host_wr_ready, .host_wr_valid,
        .host_wr_addr, .host_wr_data, .freeze, .track(track.memory)
    );

endmodule

/* rtl/decode_stage.sv */
// instruction decode and register file
`timescale 1ns/10ps
`include "cpu_macros.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`CPU_XLEN-1:0] instr,
    input  logic                 instr_valid,
    input  logic                 freeze,
    reg_track_if.decode          track,
    output logic                 stall,
    output cpu_pkg::id_ex_t      id_ex
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];
    opcode_t              op;
    reg_idx_t             rd, rs, rt;
    logic                 wr_en;
    logic                 use_rs, use_rt, use_rd;
    id_ex_t               id_ex_next;

    assign rd = instr[23:20];
    assign rs = instr[19:16];
    assign rt = instr[15:12];

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (track.wb_en && (track.wb_rd != '0)) begin
            regs[track.wb_rd] <= track.wb_data;
        end
    end

    // r0 reads zero, same-cycle writeback passes through
    function automatic logic [`CPU_XLEN-1:0] read_reg(input reg_idx_t idx);
        logic [`CPU_XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (track.wb_en && (track.wb_rd == idx)) begin
            val = track.wb_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    ////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////

    always_comb begin
        case (instr[31:24])
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_ADDI, OP_LW, OP_SW: op = opcode_t'(instr[31:24]);
            default:               op = OP_NOP;  // unknown acts as nop
        endcase
    end

    assign wr_en  = (op != OP_NOP) && (op != OP_SW);
    assign use_rs = (op != OP_NOP);
    assign use_rt = (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR});
    assign use_rd = (op == OP_SW);  // store data comes from rd

    // read-after-write against EX and EX/MEM
    function automatic logic pending(input reg_idx_t idx);
        logic in_ex, in_mem;
        in_ex  = id_ex.valid && id_ex.wr_en && (id_ex.rd == idx);
        in_mem = track.ex_wr_en && (track.ex_rd == idx);
        return (idx != '0) && (in_ex || in_mem);
    endfunction

    assign stall = instr_valid && ((use_rs && pending(rs)) ||
                                   (use_rt && pending(rt)) ||
                                   (use_rd && pending(rd)));

    always_comb begin
        id_ex_next = '0;  // bubble
        if (instr_valid && !stall) begin
            id_ex_next.valid  = 1'b1;
            id_ex_next.op     = op;
            id_ex_next.rd     = rd;
            id_ex_next.wr_en  = wr_en;
            id_ex_next.rs_val = read_reg(rs);
            id_ex_next.rt_val = read_reg(rt);
            id_ex_next.st_val = read_reg(rd);
            id_ex_next.imm    = {{(`CPU_XLEN-16){instr[15]}}, instr[15:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!freeze) begin
            id_ex <= id_ex_next;
        end
    end

endmodule

/* rtl/execute_stage.sv */
// alu stage
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::id_ex_t id_ex,
    input  logic            freeze,
    reg_track_if.execute    track,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_out;

    // immediate for addi and address forms
    assign op_b = (id_ex.op inside {OP_ADDI, OP_LW, OP_SW}) ? id_ex.imm : id_ex.rt_val;

    always_comb begin
        case (id_ex.op)
            OP_ADD, OP_ADDI,
            OP_LW, OP_SW: alu_out = id_ex.rs_val + op_b;  // wraps
            OP_SUB:       alu_out = id_ex.rs_val - op_b;
            OP_AND:       alu_out = id_ex.rs_val & op_b;
            OP_OR:        alu_out = id_ex.rs_val | op_b;
            OP_XOR:       alu_out = id_ex.rs_val ^ op_b;
            default:      alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!freeze) begin
            ex_mem.valid   <= id_ex.valid;
            ex_mem.op      <= id_ex.op;
            ex_mem.rd      <= id_ex.rd;
            ex_mem.wr_en   <= id_ex.valid && id_ex.wr_en;
            ex_mem.result  <= alu_out;
            ex_mem.st_data <= id_ex.st_val;
        end
    end

    assign track.ex_wr_en = ex_mem.valid && ex_mem.wr_en;
    assign track.ex_rd    = ex_mem.rd;

endmodule

/* rtl/fetch_stage.sv */
// instruction fetch and program load
`timescale 1ns/10ps
`include "cpu_macros.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 prog_valid,
    output logic                 prog_ready,
    input  logic [`CPU_XLEN-1:0] prog_data,
    input  logic                 prog_last,
    input  logic                 stall,
    input  logic                 freeze,
    output logic [`CPU_XLEN-1:0] instr,
    output logic                 instr_valid
);
    import cpu_pkg::*;

    localparam int IM_AW = $clog2(`CPU_IM_DEPTH);

    fetch_state_t         state;
    logic [IM_AW:0]       load_cnt;  // program length once running
    logic [IM_AW:0]       pc;        // word index
    logic [`CPU_XLEN-1:0] imem [`CPU_IM_DEPTH];
    logic                 load_fire;
    logic                 advance;
    logic                 at_end;

    assign prog_ready = (state == LOAD);
    assign load_fire  = prog_valid && prog_ready;
    assign advance    = (state == RUN) && !stall && !freeze;
    assign at_end     = (pc == load_cnt);  // past the program, bubbles only

    // load FSM, last word starts execution
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LOAD;
            load_cnt <= '0;
        end else if (load_fire) begin
            load_cnt <= load_cnt + 1'b1;
            if (prog_last) begin
                state <= RUN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_fire) begin
            imem[load_cnt[IM_AW-1:0]] <= prog_data;
        end
    end

    // pc and IF/ID valid, held on stall or freeze
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (advance) begin
            instr_valid <= !at_end;
            if (!at_end) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !at_end) begin
            instr <= imem[pc[IM_AW-1:0]];  // sync read into IF/ID
        end
    end

endmodule

/* rtl/memory_stage.sv */
// data memory and host write port
`timescale 1ns/10ps
`include "cpu_macros.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_pkg::ex_mem_t       ex_mem,
    input  logic                   host_wr_ready,
    output logic                   host_wr_valid,
    output logic [`CPU_ADDR_W-1:0] host_wr_addr,
    output logic [`CPU_XLEN-1:0]   host_wr_data,
    output logic                   freeze,
    reg_track_if.memory            track
);
    import cpu_pkg::*;

    localparam int DM_AW = $clog2(`CPU_DM_DEPTH);

    logic [`CPU_XLEN-1:0]   dmem [`CPU_DM_DEPTH];
    logic [`CPU_ADDR_W-1:0] addr;
    logic [DM_AW-1:0]       widx;
    logic                   is_host;
    logic                   is_ld, is_st;
    logic [`CPU_XLEN-1:0]   ld_data;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    assign addr    = ex_mem.result[`CPU_ADDR_W-1:0];
    assign widx    = addr[DM_AW+1:2];
    assign is_host = (addr >= `CPU_HOST_BASE);
    assign is_ld   = ex_mem.valid && (ex_mem.op == OP_LW);
    assign is_st   = ex_mem.valid && (ex_mem.op == OP_SW);

    // host stores leave the core, stalled pipe keeps them stable
    assign host_wr_valid = is_st && is_host;
    assign host_wr_addr  = addr;
    assign host_wr_data  = ex_mem.st_data;
    assign freeze        = host_wr_valid && !host_wr_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_DM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (is_st && !is_host) begin
            dmem[widx] <= ex_mem.st_data;
        end
    end

    assign ld_data = is_host ? '0 : dmem[widx];  // host region reads zero

    ////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            track.wb_en <= 1'b0;
        end else if (!freeze) begin
            track.wb_en <= ex_mem.valid && ex_mem.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            track.wb_rd   <= ex_mem.rd;
            track.wb_data <= is_ld ? ld_data : ex_mem.result;
        end
    end

endmodule

/* rtl/reg_track_if.sv */
// register write tracking
`timescale 1ns/10ps
`include "cpu_macros.svh"

interface reg_track_if;
    import cpu_pkg::*;

    // pending write held in the EX/MEM register
    logic                 ex_wr_en;
    reg_idx_t             ex_rd;

    // writeback from the MEM/WB register
    logic                 wb_en;
    reg_idx_t             wb_rd;
    logic [`CPU_XLEN-1:0] wb_data;

    modport execute (output ex_wr_en, ex_rd);
    modport memory  (output wb_en, wb_rd, wb_data);
    modport decode  (input ex_wr_en, ex_rd, wb_en, wb_rd, wb_data);

endinterface

/* testbench/clock_gen.sv */
// testbench clock and reset
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/tb_cpu.sv */
// cpu core testbench
`timescale 1ns/10ps
`include "cpu_macros.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int NUM_INSTR      = 40;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 16 + 500;

    logic                   clk, rst_n;
    logic                   prog_valid, prog_ready, prog_last;
    logic [`CPU_XLEN-1:0]   prog_data;
    logic                   host_wr_valid, host_wr_ready;
    logic [`CPU_ADDR_W-1:0] host_wr_addr;
    logic [`CPU_XLEN-1:0]   host_wr_data;

    logic [`CPU_XLEN-1:0]   prog_q [$];
    logic [`CPU_ADDR_W-1:0] exp_addr [$];  // host writes in program order
    logic [`CPU_XLEN-1:0]   exp_data [$];
    logic [7:0]             alu_ops [7] = '{OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, 8'hff};
    int                     total_writes = 0;
    int                     writes_seen  = 0;
    int                     cycles       = 0;
    logic                   load_done    = 1'b0;
    logic                   held         = 1'b0;  // write waiting on ready
    logic [`CPU_ADDR_W-1:0] held_addr, want_addr;
    logic [`CPU_XLEN-1:0]   held_data, want_data;

    clock_gen u_clk (.clk, .rst_n);

    cpu_top DUT (
        .clk, .rst_n, .prog_valid, .prog_ready, .prog_data, .prog_last,
        .host_wr_valid, .host_wr_ready, .host_wr_addr, .host_wr_data
    );

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("Error at %0t: %s", $time, reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] encode(input logic [7:0] op, input int rd, input int rs,
                                           input logic [15:0] low);
        return {op, 4'(rd), 4'(rs), low};
    endfunction

    ////////////////////////////////////////
    // program and reference model
    ////////////////////////////////////////

    task automatic build_program();
        int kind, rd, rs, rt, slot;
        // dependent chain with each result sent to the host
        prog_q.push_back(encode(OP_ADDI, 1, 0, 16'hffff));        // r1 = -1
        prog_q.push_back(encode(OP_SW,   1, 0, 16'h9000));
        prog_q.push_back(encode(OP_ADDI, 2, 1, 16'h0001));        // wraps to zero
        prog_q.push_back(encode(OP_SW,   2, 0, 16'h9004));
        prog_q.push_back(encode(OP_ADDI, 3, 2, 16'h7ff3));
        prog_q.push_back(encode(OP_SUB,  4, 2, {4'd3, 12'h0}));
        prog_q.push_back(encode(OP_SW,   4, 0, 16'h9008));
        prog_q.push_back(encode(OP_XOR,  5, 4, {4'd1, 12'h0}));
        prog_q.push_back(encode(OP_SW,   5, 0, 16'h900c));
        prog_q.push_back(encode(OP_AND,  6, 4, {4'd5, 12'h0}));
        prog_q.push_back(encode(OP_SW,   6, 0, 16'h901c));
        prog_q.push_back(encode(OP_OR,   7, 3, {4'd5, 12'h0}));
        prog_q.push_back(encode(OP_SW,   7, 0, 16'h9020));
        prog_q.push_back(encode(OP_ADDI, 0, 5, 16'h0123));        // r0 stays zero
        prog_q.push_back(encode(OP_SW,   0, 0, 16'h9010));
        prog_q.push_back(encode(OP_SW,   5, 1, 16'h0041));        // base r1 wraps to 0x40
        prog_q.push_back(encode(OP_LW,   6, 1, 16'h0041));
        prog_q.push_back(encode(OP_SW,   6, 0, 16'h9014));
        prog_q.push_back(encode(OP_LW,   7, 0, 16'h00fc));        // never written
        prog_q.push_back(encode(OP_SW,   7, 0, 16'h9018));
        while (prog_q.size() < NUM_INSTR) begin
            kind = $urandom_range(0, 9);
            rd   = $urandom_range(0, 7);
            rs   = $urandom_range(0, 7);
            rt   = $urandom_range(0, 7);
            slot = $urandom_range(0, 63);
            case (kind)
                0, 1, 2: prog_q.push_back(encode(alu_ops[$urandom_range(0, 6)], rd, rs,
                                                 {4'(rt), 12'($urandom())}));
                3:       prog_q.push_back(encode(OP_ADDI, rd, rs, 16'($urandom())));
                4, 5, 6: prog_q.push_back(encode(OP_SW, rd, 0, 16'(`CPU_HOST_BASE + slot * 4)));
                7:       prog_q.push_back(encode(OP_SW, rd, 0, 16'(4 * (slot % 8))));
                8:       prog_q.push_back(encode(OP_LW, rd, 0, 16'(4 * (slot % 8))));
                default: prog_q.push_back(encode(OP_LW, rd, 0, 16'(`CPU_HOST_BASE + slot * 4)));
            endcase
        end
    endtask

    // in-order execution of the whole program
    task automatic run_model();
        logic [`CPU_XLEN-1:0]   regs [`CPU_REG_COUNT];
        logic [`CPU_XLEN-1:0]   dmem [`CPU_DM_DEPTH];
        logic [`CPU_XLEN-1:0]   w, a, b, imm, res;
        logic [`CPU_ADDR_W-1:0] addr;
        logic                   wr;
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        foreach (prog_q[i]) begin
            w    = prog_q[i];
            a    = regs[w[19:16]];
            b    = regs[w[15:12]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = 16'(a + imm);
            wr   = 1'b1;
            res  = '0;
            case (w[31:24])
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + imm;
                OP_LW:   res = (addr >= `CPU_HOST_BASE) ? '0 : dmem[addr[7:2]];
                OP_SW: begin
                    wr = 1'b0;
                    if (addr >= `CPU_HOST_BASE) begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(regs[w[23:20]]);
                    end else begin
                        dmem[addr[7:2]] = regs[w[23:20]];
                    end
                end
                default: wr = 1'b0;  // nop and unknown opcodes
            endcase
            if (wr && (w[23:20] != 4'd0)) begin
                regs[w[23:20]] = res;
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        int idx;
        prog_valid = 1'b0;
        prog_data  = '0;
        prog_last  = 1'b0;
        void'($urandom(32'h251600f0));
        build_program();
        run_model();
        total_writes = exp_addr.size();
        idx = 0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        check_value("host_wr_valid", 32'(host_wr_valid), 32'd0);
        while (idx < NUM_INSTR) begin
            check_value("prog_ready", 32'(prog_ready), 32'd1);
            if (prog_valid && prog_ready) begin
                idx++;  // word taken at this edge
            end
            if ((idx < NUM_INSTR) && ($urandom_range(0, 3) != 0)) begin
                prog_valid <= 1'b1;
                prog_data  <= prog_q[idx];
                prog_last  <= (idx == NUM_INSTR - 1);
            end else begin
                prog_valid <= 1'b0;
                prog_last  <= 1'b0;
            end
            @(posedge clk);
        end
        check_value("prog_ready", 32'(prog_ready), 32'd0);
        load_done = 1'b1;
        while (writes_seen < total_writes) begin
            @(posedge clk);
        end
        repeat (200) begin
            @(posedge clk);
            check_value("host_wr_valid", 32'(host_wr_valid), 32'd0);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // host side back-pressure
    initial begin
        host_wr_ready = 1'b0;
        forever begin
            @(posedge clk);
            host_wr_ready <= ($urandom_range(0, 2) != 0);
        end
    end

    ////////////////////////////////////////
    // host write monitor and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (load_done) begin
            check_value("prog_ready", 32'(prog_ready), 32'd0);
        end
        if (rst_n && host_wr_valid) begin
            if (held) begin  // stalled write must not move
                check_value("host_wr_addr", 32'(host_wr_addr), 32'(held_addr));
                check_value("host_wr_data", host_wr_data, held_data);
            end
            if (host_wr_ready) begin
                if (exp_addr.size() == 0) begin
                    stop_run("host write seen with none left to expect");
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    check_value("host_wr_addr", 32'(host_wr_addr), 32'(want_addr));
                    check_value("host_wr_data", host_wr_data, want_data);
                    writes_seen++;
                    held = 1'b0;
                end
            end else begin
                held      = 1'b1;
                held_addr = host_wr_addr;
                held_data = host_wr_data;
            end
        end else if (held) begin
            stop_run("host write withdrawn before it was accepted");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_run("the run hung, host writes still outstanding at the cycle limit");
        end
    end

endmodule
